//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := decode_stage_tb
FILELIST  := decode_stage_top.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@! grep -q "TEST FAILED" $(LOG)
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- decode_stage_top.f
verilog/rv_decode_pkg.sv
verilog/inst_queue.sv
verilog/imm_gen.sv
verilog/operand_read.sv
verilog/decode_unit.sv
verilog/decode_stage_top.sv
verification/tb_clock_gen.sv
verification/decode_stage_properties.sv
verification/decode_stage_tb.sv

//--- verification/decode_stage_properties.sv
`timescale 1ns/100ps

module decode_stage_properties import rv_decode_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       flush,
    input logic       dec_valid,
    input logic       dec_ready,
    input xlen_t      dec_pc,
    input inst_t      dec_inst,
    input xlen_t      dec_imm,
    input inst_type_t dec_type,
    input reg_idx_t   dec_rs1,
    input reg_idx_t   dec_rs2,
    input xlen_t      dec_src_a,
    input xlen_t      dec_src_b,
    input logic       ex_load_valid,
    input reg_idx_t   ex_load_rd
);

    logic rs2_used;
    logic load_hit;

    assign rs2_used = dec_type[4] || dec_type[8] || dec_type[10];  // branch, alu_r, alu_rw
    assign load_hit = ex_load_valid && (ex_load_rd != 5'd0)
                    && ((ex_load_rd == dec_rs1) || (rs2_used && (ex_load_rd == dec_rs2)));

    // valid must be a known level once out of reset
    valid_known: assert property (@(posedge clk) !reset |-> !$isunknown(dec_valid))
        else $error("dec_valid unknown after reset");

    reset_clears_valid: assert property (@(posedge clk) reset |=> !dec_valid)
        else $error("dec_valid high after reset");

    // payload frozen while execute holds off
    hold_stable: assert property (@(posedge clk) disable iff (reset)
        (dec_valid && !dec_ready && !flush) |=>
            ($stable(dec_pc) && $stable(dec_inst) && $stable(dec_imm)
             && $stable(dec_type) && $stable(dec_src_a) && $stable(dec_src_b)))
        else $error("dec outputs changed under back-pressure");

    load_use_blocks: assert property (@(posedge clk) disable iff (reset)
        load_hit |-> !dec_valid)
        else $error("dec_valid high during load-use hazard");

    flush_empties: assert property (@(posedge clk) disable iff (reset)
        flush |=> !dec_valid)
        else $error("dec_valid high in cycle after flush");

endmodule

//--- verification/decode_stage_tb.sv
`timescale 1ns/100ps

module decode_stage_tb import rv_decode_pkg::*; ();

    localparam int DEPTH    = 16;
    localparam int SLACK    = 4;
    localparam int N_RANDOM = 400;
    // random phase is one cycle per loop step, directed phases add ~150
    localparam int TIMEOUT_CYCLES = 3000;

    typedef struct packed {
        xlen_t      pc;
        inst_t      inst;
        inst_type_t itype;
        xlen_t      imm;
        xlen_t      src_a;
        xlen_t      src_b;
    } expect_t;

    logic clk, reset, flush;
    logic fetch_valid, fetch_ready, dec_valid, dec_ready;
    xlen_t fetch_pc, dec_pc, dec_imm, dec_src_a, dec_src_b, wb_data;
    inst_t fetch_inst, dec_inst;
    reg_idx_t dec_rd, dec_rs1, dec_rs2, ex_load_rd, wb_rd;
    logic [2:0] dec_funct3;
    inst_type_t dec_type;
    logic ex_load_valid, wb_en;
    xlen_t csr_mtvec, csr_mepc, csr_mcause, csr_mstatus;

    expect_t exp_q[$];
    xlen_t shadow[32];            // register file model
    xlen_t next_pc;
    int cycles;
    int seed_val;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(2)) u_clk (.clk(clk), .reset(reset));

    decode_stage_top #(.QUEUE_DEPTH(DEPTH), .QUEUE_SLACK(SLACK)) dut (.*);

    bind decode_stage_top decode_stage_properties u_props (
        .clk(clk), .reset(reset), .flush(flush), .dec_valid(dec_valid),
        .dec_ready(dec_ready), .dec_pc(dec_pc), .dec_inst(dec_inst), .dec_imm(dec_imm),
        .dec_type(dec_type), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
        .dec_src_a(dec_src_a), .dec_src_b(dec_src_b),
        .ex_load_valid(ex_load_valid), .ex_load_rd(ex_load_rd)
    );

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0d ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // major opcode per class index, encoding table of the isa
    function automatic logic [6:0] class_opcode(input int c);
        case (c)
            0:       return 7'b0110111;  // lui
            1:       return 7'b0010111;  // auipc
            2:       return 7'b1101111;  // jal
            3:       return 7'b1100111;  // jalr
            4:       return 7'b1100011;  // branch
            5:       return 7'b0000011;  // load
            6:       return 7'b0100011;  // store
            7:       return 7'b0010011;  // op-imm
            8:       return 7'b0110011;  // op
            9:       return 7'b0011011;  // op-imm-32
            10:      return 7'b0111011;  // op-32
            default: return 7'b1110011;  // system
        endcase
    endfunction

    function automatic int classify(input inst_t in);
        for (int c = 0; c < 11; c++) begin
            if (in[6:0] == class_opcode(c)) return c;
        end
        if (in[6:0] != 7'b1110011) return -1;        // unknown opcode
        if (in[14:12] != 3'b000) return 11;           // csr ops
        if (in == 32'h0010_0073) return 12;
        if (in == 32'h0000_0073) return 13;
        if (in == 32'h3020_0073) return 14;
        return -1;
    endfunction

    function automatic xlen_t sext(input xlen_t v, input int w);
        return xlen_t'($signed(v << (64 - w)) >>> (64 - w));
    endfunction

    function automatic xlen_t ref_imm(input inst_t in, input int c);
        case (c)
            6:       return sext(xlen_t'({in[31:25], in[11:7]}), 12);
            4:       return sext(xlen_t'({in[31], in[7], in[30:25], in[11:8], 1'b0}), 13);
            0, 1:    return sext(xlen_t'({in[31:12], 12'h000}), 32);
            2:       return sext(xlen_t'({in[31], in[19:12], in[20], in[30:21], 1'b0}), 21);
            default: return sext(xlen_t'(in[31:20]), 12);  // i layout, unknown too
        endcase
    endfunction

    function automatic xlen_t csr_by_addr(input logic [11:0] a);
        case (a)
            12'h300: return csr_mstatus;
            12'h305: return csr_mtvec;
            12'h341: return csr_mepc;
            12'h342: return csr_mcause;
            default: return '0;
        endcase
    endfunction

    function automatic expect_t build_expect(input xlen_t pc, input inst_t in);
        expect_t e;
        int c;
        c = classify(in);
        e.pc    = pc;
        e.inst  = in;
        e.itype = (c < 0) ? '0 : inst_type_t'(15'd1 << c);
        e.imm   = ref_imm(in, c);
        e.src_a = shadow[in[19:15]];
        if (c == 11) e.src_b = csr_by_addr(in[31:20]);
        else if (c == 13) e.src_b = csr_mtvec;
        else if (c == 14) e.src_b = csr_mepc;
        else e.src_b = shadow[in[24:20]];
        return e;
    endfunction

    // random word of a class, 15 gives an unknown opcode
    function automatic inst_t gen_inst(input int c);
        logic [31:0] r;
        logic [11:0] addr;
        r = $urandom;
        case (c)
            11: begin
                case ($urandom_range(0, 4))
                    0:       addr = 12'h300;
                    1:       addr = 12'h305;
                    2:       addr = 12'h341;
                    3:       addr = 12'h342;
                    default: addr = 12'h7c0;     // not implemented, reads zero
                endcase
                return {addr, r[19:15], 3'($urandom_range(1, 7)), r[11:7], 7'b1110011};
            end
            12:      return 32'h0010_0073;
            13:      return 32'h0000_0073;
            14:      return 32'h3020_0073;
            15:      return {r[31:7], 7'b1111111};
            default: return {r[31:7], class_opcode(c)};
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // one fetch beat, always taken while credit is available
    task automatic send_one(input inst_t in);
        while (!fetch_ready) next_cycle();
        fetch_valid = 1'b1;
        fetch_pc    = next_pc;
        fetch_inst  = in;
        exp_q.push_back(build_expect(next_pc, in));
        next_pc = next_pc + 64'd4;
        next_cycle();
        fetch_valid = 1'b0;
    endtask

    task automatic wait_drained(input int limit);
        int k;
        k = 0;
        while (exp_q.size() != 0) begin
            next_cycle();
            k++;
            if (k > limit) report_error("items were not delivered in time");
        end
    endtask

    task automatic check_output(input expect_t e);
        assert (dec_pc == e.pc) else report_mismatch($sformatf("pc %h exp %h", dec_pc, e.pc));
        assert (dec_inst == e.inst)
            else report_mismatch($sformatf("inst %h exp %h", dec_inst, e.inst));
        assert (dec_rd == e.inst[11:7]) else report_mismatch("rd field wrong");
        assert (dec_rs1 == e.inst[19:15]) else report_mismatch("rs1 field wrong");
        assert (dec_rs2 == e.inst[24:20]) else report_mismatch("rs2 field wrong");
        assert (dec_funct3 == e.inst[14:12]) else report_mismatch("funct3 wrong");
        assert (dec_type == e.itype)
            else report_mismatch($sformatf("type %h exp %h inst %h", dec_type, e.itype, e.inst));
        assert (dec_imm == e.imm)
            else report_mismatch($sformatf("imm %h exp %h inst %h", dec_imm, e.imm, e.inst));
        assert (dec_src_a == e.src_a) else report_mismatch("src_a differs from rs1 value");
        assert (dec_src_b == e.src_b)
            else report_mismatch($sformatf("src_b %h exp %h inst %h", dec_src_b, e.src_b, e.inst));
    endtask

    always @(posedge clk) begin
        if (!reset && dec_valid && dec_ready) begin
            if (exp_q.size() == 0) report_error("output delivered with nothing outstanding");
            check_output(exp_q.pop_front());
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    initial begin
        int n;
        seed_val      = $urandom(32'ha75f);
        flush         = 1'b0;
        fetch_valid   = 1'b0;
        fetch_pc      = '0;
        fetch_inst    = '0;
        dec_ready     = 1'b0;
        ex_load_valid = 1'b0;
        ex_load_rd    = '0;
        wb_en         = 1'b0;
        wb_rd         = '0;
        wb_data       = '0;
        csr_mtvec     = 64'h8000_0100;
        csr_mepc      = 64'h8000_2468;
        csr_mcause    = 64'h8000_0000_0000_000b;
        csr_mstatus   = 64'h0000_0000_0000_1888;
        cycles        = 0;
        next_pc       = 64'h8000_0000;
        for (int i = 0; i < 32; i++) shadow[i] = '0;

        @(negedge reset);
        next_cycle();
        assert (!dec_valid) else report_mismatch("dec_valid high after reset");
        assert (fetch_ready) else report_mismatch("fetch_ready low after reset");

        // fill the register file, x0 write must be dropped
        for (int i = 0; i < 32; i++) begin
            wb_en   = 1'b1;
            wb_rd   = 5'(i);
            wb_data = {$urandom, $urandom};
            if (i != 0) shadow[i] = wb_data;
            next_cycle();
        end
        wb_en = 1'b0;

        // random classes with random back-pressure, idle while credit is out
        for (int i = 0; i < N_RANDOM; i++) begin
            dec_ready = 1'($urandom_range(0, 1));
            if (fetch_ready && ($urandom_range(0, 3) != 0)) send_one(gen_inst(i % 16));
            else next_cycle();
        end
        dec_ready = 1'b1;
        wait_drained(2 * DEPTH);

        // credit drops at depth minus slack
        dec_ready = 1'b0;
        n = 0;
        while (fetch_ready) begin
            send_one(gen_inst($urandom_range(0, 15)));
            n++;
            if (n > DEPTH) report_error("fetch_ready never dropped");
        end
        assert (n == DEPTH - SLACK)
            else report_mismatch($sformatf("fetch_ready dropped after %0d items", n));
        dec_ready = 1'b1;
        wait_drained(2 * DEPTH);

        // load-use on rs1, then on rs2 of a reg-reg op
        ex_load_valid = 1'b1;
        ex_load_rd    = 5'd5;
        send_one({12'h123, 5'd5, 3'b000, 5'd7, 7'b0010011});     // addi x7, x5
        repeat (4) begin
            assert (!dec_valid) else report_mismatch("dec_valid high during rs1 stall");
            next_cycle();
        end
        ex_load_valid = 1'b0;
        wait_drained(10);
        ex_load_valid = 1'b1;
        send_one({7'h00, 5'd5, 5'd2, 3'b000, 5'd9, 7'b0110011});  // add x9, x2, x5
        repeat (3) begin
            assert (!dec_valid) else report_mismatch("dec_valid high during rs2 stall");
            next_cycle();
        end
        ex_load_valid = 1'b0;
        wait_drained(10);
        // load has no rs2, bits 24:20 are immediate
        ex_load_valid = 1'b1;
        send_one({7'h00, 5'd5, 5'd3, 3'b011, 5'd10, 7'b0000011});
        wait_drained(10);
        ex_load_valid = 1'b0;

        // flush drops queued items and the one held in decode
        dec_ready = 1'b0;
        repeat (5) send_one(gen_inst($urandom_range(0, 15)));
        dec_ready = 1'b1;                // head moves into the register
        next_cycle();
        dec_ready = 1'b0;                // held there, not taken
        flush     = 1'b1;
        exp_q.delete();
        next_cycle();
        flush = 1'b0;
        assert (!dec_valid) else report_mismatch("dec_valid high after flush");
        dec_ready = 1'b1;
        repeat (3) send_one(gen_inst($urandom_range(0, 15)));
        wait_drained(10);
        repeat (4) next_cycle();         // a late duplicate would reach the monitor

        $display("TEST OK");
        $finish;
    end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0;  // released just after the edge like other inputs
    end

endmodule

//--- verilog/decode_stage_top.sv
`timescale 1ns/100ps

// operand request from decode, answered in the same cycle
interface operand_if import rv_decode_pkg::*; ();
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    csr_addr_t  csr_addr;
    src_b_sel_e b_sel;
    xlen_t      src_a;
    xlen_t      src_b;

    modport requester (output rs1, rs2, csr_addr, b_sel, input src_a, src_b);
    modport responder (input rs1, rs2, csr_addr, b_sel, output src_a, src_b);
endinterface

module decode_stage_top import rv_decode_pkg::*; #(
    parameter int QUEUE_DEPTH = 16,
    parameter int QUEUE_SLACK = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       fetch_valid,
    output logic       fetch_ready,
    input  xlen_t      fetch_pc,
    input  inst_t      fetch_inst,
    output logic       dec_valid,
    input  logic       dec_ready,
    output xlen_t      dec_pc,
    output inst_t      dec_inst,
    output reg_idx_t   dec_rd,
    output reg_idx_t   dec_rs1,
    output reg_idx_t   dec_rs2,
    output logic [2:0] dec_funct3,
    output inst_type_t dec_type,
    output xlen_t      dec_imm,
    output xlen_t      dec_src_a,
    output xlen_t      dec_src_b,
    input  logic       ex_load_valid,
    input  reg_idx_t   ex_load_rd,
    input  logic       wb_en,
    input  reg_idx_t   wb_rd,
    input  xlen_t      wb_data,
    input  xlen_t      csr_mtvec,
    input  xlen_t      csr_mepc,
    input  xlen_t      csr_mcause,
    input  xlen_t      csr_mstatus
);

    operand_if ops ();

    decode_unit #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .QUEUE_SLACK (QUEUE_SLACK)
    ) u_decode (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .fetch_valid   (fetch_valid),
        .fetch_ready   (fetch_ready),
        .fetch_pc      (fetch_pc),
        .fetch_inst    (fetch_inst),
        .dec_valid     (dec_valid),
        .dec_ready     (dec_ready),
        .dec_pc        (dec_pc),
        .dec_inst      (dec_inst),
        .dec_rd        (dec_rd),
        .dec_rs1       (dec_rs1),
        .dec_rs2       (dec_rs2),
        .dec_funct3    (dec_funct3),
        .dec_type      (dec_type),
        .dec_imm       (dec_imm),
        .ex_load_valid (ex_load_valid),
        .ex_load_rd    (ex_load_rd),
        .ops           (ops.requester)
    );

    operand_read u_operand (
        .clk         (clk),
        .reset       (reset),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .csr_mtvec   (csr_mtvec),
        .csr_mepc    (csr_mepc),
        .csr_mcause  (csr_mcause),
        .csr_mstatus (csr_mstatus),
        .ops         (ops.responder)
    );

    assign dec_src_a = ops.src_a;  // operands ride with the decoded item
    assign dec_src_b = ops.src_b;

endmodule

//--- verilog/decode_unit.sv
`timescale 1ns/100ps

module decode_unit import rv_decode_pkg::*; #(
    parameter int QUEUE_DEPTH = 16,
    parameter int QUEUE_SLACK = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,          // branch flush
    input  logic       fetch_valid,
    output logic       fetch_ready,    // credit, low at almost full
    input  xlen_t      fetch_pc,
    input  inst_t      fetch_inst,
    output logic       dec_valid,
    input  logic       dec_ready,
    output xlen_t      dec_pc,
    output inst_t      dec_inst,
    output reg_idx_t   dec_rd,
    output reg_idx_t   dec_rs1,
    output reg_idx_t   dec_rs2,
    output logic [2:0] dec_funct3,
    output inst_type_t dec_type,
    output xlen_t      dec_imm,
    input  logic       ex_load_valid,  // load sitting in execute
    input  reg_idx_t   ex_load_rd,
    operand_if.requester ops
);

    logic       q_wr_en;
    logic       q_rd_en;
    xlen_t      q_pc;
    inst_t      q_inst;
    logic       q_almost_full;
    logic       q_empty;
    logic       advance;        // decode register may take a new item
    logic       stall;          // load-use interlock
    logic       reg_valid;
    xlen_t      reg_pc;
    inst_t      reg_inst;
    inst_t      inst;           // word actually decoded
    logic [6:0] opcode;
    logic [2:0] funct3;
    inst_type_t itype;
    logic       rs2_used;

    assign advance     = dec_ready && !stall;
    assign q_wr_en     = fetch_valid && !(q_empty && advance);  // else bypass
    assign q_rd_en     = advance && !q_empty;
    assign fetch_ready = !q_almost_full;

    inst_queue #(
        .DEPTH (QUEUE_DEPTH),
        .SLACK (QUEUE_SLACK)
    ) u_queue (
        .clk         (clk),
        .reset       (reset),
        .clear       (flush),
        .wr_en       (q_wr_en),
        .wr_pc       (fetch_pc),
        .wr_inst     (fetch_inst),
        .rd_en       (q_rd_en),
        .rd_pc       (q_pc),
        .rd_inst     (q_inst),
        .almost_full (q_almost_full),
        .empty       (q_empty)
    );

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            reg_valid <= 1'b0;
        end else if (advance) begin
            reg_valid <= q_empty ? fetch_valid : 1'b1;
        end
    end

    // payload, valid bit above qualifies it
    always_ff @(posedge clk) begin
        if (advance) begin
            reg_pc   <= q_empty ? fetch_pc : q_pc;
            reg_inst <= q_empty ? fetch_inst : q_inst;
        end
    end

    assign inst   = reg_valid ? reg_inst : '0;  // empty slot decodes as zero
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    always_comb begin
        itype              = '0;
        itype[CLS_LUI]     = (opcode == OPC_LUI);
        itype[CLS_AUIPC]   = (opcode == OPC_AUIPC);
        itype[CLS_JAL]     = (opcode == OPC_JAL);
        itype[CLS_JALR]    = (opcode == OPC_JALR);
        itype[CLS_BRANCH]  = (opcode == OPC_BRANCH);
        itype[CLS_LOAD]    = (opcode == OPC_LOAD);
        itype[CLS_STORE]   = (opcode == OPC_STORE);
        itype[CLS_ALU_I]   = (opcode == OPC_OP_IMM);
        itype[CLS_ALU_R]   = (opcode == OPC_OP);
        itype[CLS_ALU_IW]  = (opcode == OPC_OP_IMM_32);
        itype[CLS_ALU_RW]  = (opcode == OPC_OP_32);
        itype[CLS_CSR]     = (opcode == OPC_SYSTEM) && (funct3 != 3'b000);
        itype[CLS_EBREAK]  = (inst == INST_EBREAK);
        itype[CLS_ECALL]   = (inst == INST_ECALL);
        itype[CLS_MRET]    = (inst == INST_MRET);
    end

    imm_gen u_imm (
        .inst  (inst),
        .itype (itype),
        .imm   (dec_imm)
    );

    // rs2 only matters for the hazard on reg-reg ops and branches
    assign rs2_used = itype[CLS_BRANCH] || itype[CLS_ALU_R] || itype[CLS_ALU_RW];
    assign stall    = reg_valid && ex_load_valid && (ex_load_rd != '0)
                    && ((ex_load_rd == dec_rs1) || (rs2_used && (ex_load_rd == dec_rs2)));

    assign ops.rs1      = dec_rs1;
    assign ops.rs2      = dec_rs2;
    assign ops.csr_addr = inst[31:20];

    always_comb begin
        if (itype[CLS_CSR]) begin
            ops.b_sel = SRC_B_CSR;
        end else if (itype[CLS_ECALL]) begin
            ops.b_sel = SRC_B_MTVEC;
        end else if (itype[CLS_MRET]) begin
            ops.b_sel = SRC_B_MEPC;
        end else begin
            ops.b_sel = SRC_B_REG;
        end
    end

    assign dec_valid  = reg_valid && !stall;  // held item reappears after stall
    assign dec_pc     = reg_pc;
    assign dec_inst   = inst;
    assign dec_rd     = inst[11:7];
    assign dec_rs1    = inst[19:15];
    assign dec_rs2    = inst[24:20];
    assign dec_funct3 = funct3;
    assign dec_type   = itype;

endmodule

//--- verilog/imm_gen.sv
`timescale 1ns/100ps

module imm_gen import rv_decode_pkg::*; (
    input  inst_t      inst,
    input  inst_type_t itype,   // one-hot class from decode
    output xlen_t      imm
);

    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_u;
    xlen_t imm_j;
    logic  sign;

    assign sign = inst[31];  // every layout sign-extends from bit 31

    // loads, jalr, alu immediates, csr
    assign imm_i = {{52{sign}}, inst[31:20]};

    // stores split the offset around rs2
    assign imm_s = {{52{sign}}, inst[31:25], inst[11:7]};

    // branch offset, halfword aligned
    assign imm_b = {{51{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    // lui and auipc, low 12 bits zero
    assign imm_u = {{32{sign}}, inst[31:12], 12'b0};

    // jal offset, halfword aligned
    assign imm_j = {{43{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        if (itype[CLS_STORE]) begin
            imm = imm_s;
        end else if (itype[CLS_BRANCH]) begin
            imm = imm_b;
        end else if (itype[CLS_LUI] || itype[CLS_AUIPC]) begin
            imm = imm_u;
        end else if (itype[CLS_JAL]) begin
            imm = imm_j;
        end else begin
            imm = imm_i;        // also unknown and empty slots
        end
    end

endmodule

//--- verilog/inst_queue.sv
`timescale 1ns/100ps

module inst_queue import rv_decode_pkg::*; #(
    parameter int DEPTH = 16,  // power of two
    parameter int SLACK = 4    // entries kept free after almost_full
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  clear,        // branch flush, drops all entries
    input  logic  wr_en,
    input  xlen_t wr_pc,
    input  inst_t wr_inst,
    input  logic  rd_en,
    output xlen_t rd_pc,        // head entry, valid when !empty
    output inst_t rd_inst,
    output logic  almost_full,
    output logic  empty
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = AW + 1;                           // count reaches DEPTH
    localparam logic [CW-1:0] FULL_LEVEL = CW'(DEPTH);
    localparam logic [CW-1:0] AF_LEVEL   = CW'(DEPTH - SLACK);

    xlen_t pc_mem [DEPTH];
    inst_t inst_mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          full;
    logic          do_wr;
    logic          do_rd;

    assign full        = (count == FULL_LEVEL);
    assign empty       = (count == '0);
    assign almost_full = (count >= AF_LEVEL);             // credit threshold
    assign do_wr       = wr_en && !full;                  // overflow writes dropped
    assign do_rd       = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            pc_mem[wr_ptr]   <= wr_pc;
            inst_mem[wr_ptr] <= wr_inst;
        end
    end

    assign rd_pc   = pc_mem[rd_ptr];                      // show-ahead head
    assign rd_inst = inst_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + AW'(1);                // wraps at DEPTH
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + AW'(1);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: count <= count;                  // both or neither
            endcase
        end
    end

endmodule

//--- verilog/operand_read.sv
`timescale 1ns/100ps

module operand_read import rv_decode_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    input  xlen_t    wb_data,
    input  xlen_t    csr_mtvec,
    input  xlen_t    csr_mepc,
    input  xlen_t    csr_mcause,
    input  xlen_t    csr_mstatus,
    operand_if.responder ops
);

    xlen_t gpr [1:31];  // x0 not stored
    xlen_t rs1_val;
    xlen_t rs2_val;
    xlen_t csr_val;

    // write-back lands at the edge, same-cycle reads see the old value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                gpr[i] <= '0;
            end
        end else if (wb_en && (wb_rd != '0)) begin
            gpr[wb_rd] <= wb_data;              // writes to x0 dropped
        end
    end

    always_comb begin
        if (ops.rs1 == '0) begin
            rs1_val = '0;                       // x0 hardwired
        end else begin
            rs1_val = gpr[ops.rs1];
        end
        if (ops.rs2 == '0) begin
            rs2_val = '0;
        end else begin
            rs2_val = gpr[ops.rs2];
        end
    end

    always_comb begin
        case (ops.csr_addr)
            CSR_MTVEC:   csr_val = csr_mtvec;
            CSR_MEPC:    csr_val = csr_mepc;
            CSR_MCAUSE:  csr_val = csr_mcause;
            CSR_MSTATUS: csr_val = csr_mstatus;
            default:     csr_val = '0;          // unimplemented csr reads zero
        endcase
    end

    assign ops.src_a = rs1_val;                 // always a register

    always_comb begin
        case (ops.b_sel)
            SRC_B_CSR:   ops.src_b = csr_val;
            SRC_B_MTVEC: ops.src_b = csr_mtvec;   // ecall
            SRC_B_MEPC:  ops.src_b = csr_mepc;    // mret
            default:     ops.src_b = rs2_val;
        endcase
    end

endmodule

//--- verilog/rv_decode_pkg.sv
package rv_decode_pkg;

    typedef logic [63:0] xlen_t;       // regs, csrs, pc, imm, operands
    typedef logic [31:0] inst_t;       // raw instruction word
    typedef logic [4:0]  reg_idx_t;    // x0..x31
    typedef logic [11:0] csr_addr_t;   // inst[31:20] of a csr op
    typedef logic [14:0] inst_type_t;  // one-hot class, all zero if unknown

    // bit positions inside inst_type_t
    typedef enum int unsigned {
        CLS_LUI    = 0,
        CLS_AUIPC  = 1,
        CLS_JAL    = 2,
        CLS_JALR   = 3,
        CLS_BRANCH = 4,
        CLS_LOAD   = 5,
        CLS_STORE  = 6,
        CLS_ALU_I  = 7,
        CLS_ALU_R  = 8,
        CLS_ALU_IW = 9,
        CLS_ALU_RW = 10,
        CLS_CSR    = 11,
        CLS_EBREAK = 12,
        CLS_ECALL  = 13,
        CLS_MRET   = 14
    } inst_class_e;

    // operand b source
    typedef enum logic [1:0] {
        SRC_B_REG   = 2'd0,  // gpr[rs2]
        SRC_B_CSR   = 2'd1,  // csr picked by address field
        SRC_B_MTVEC = 2'd2,  // ecall target
        SRC_B_MEPC  = 2'd3   // mret target
    } src_b_sel_e;

    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;  // csr, ecall, ebreak, mret

    localparam inst_t INST_ECALL  = 32'h0000_0073;
    localparam inst_t INST_EBREAK = 32'h0010_0073;
    localparam inst_t INST_MRET   = 32'h3020_0073;

    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

endpackage
